/* upct.f */
+incdir+hdl
hdl/upct_pkg.sv
hdl/upct_update_in.sv
hdl/upct_plru.sv
hdl/upct_table.sv
hdl/upct_target_out.sv
hdl/upct_top.sv
test/upct_tb.sv

/* test/upct_tb.sv */
`include "upct_cfg.svh"

module upct_tb
    import upct_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // Tests need about 450 cycles
    localparam int MAX_CYCLES = 2000;
    localparam int RSP_WAIT   = 10;

    logic        CLK;
    logic        nRST;
    logic        update_valid;
    full_pc_t    update_pc;
    logic        read_valid;
    read_req_t   read_req;
    logic        update_rsp_valid;
    update_rsp_t update_rsp;
    logic        target_valid;
    full_pc_t    target_pc;

    int errors      = 0;
    int checks      = 0;
    int cycle_count = 0;

    // Reference model, state after the next rising edge
    upper_pc_t   m_array [`UPCT_ENTRIES];
    plru_t       m_plru;
    logic        m_u1_valid;
    upper_pc_t   m_u1_upper;
    logic        m_r1_valid;
    read_req_t   m_r1_req;
    logic        exp_rsp_valid;
    update_rsp_t exp_rsp;
    logic        exp_tgt_valid;
    full_pc_t    exp_tgt;

    // Upper value each entry holds, as the directed tests wrote it
    upper_pc_t   stored [`UPCT_ENTRIES];

    upct_top u_upct_top (
        .CLK              (CLK),
        .nRST             (nRST),
        .update_valid     (update_valid),
        .update_pc        (update_pc),
        .read_valid       (read_valid),
        .read_req         (read_req),
        .update_rsp_valid (update_rsp_valid),
        .update_rsp       (update_rsp),
        .target_valid     (target_valid),
        .target_pc        (target_pc)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // ------------------------------------------------------------------------
    // Model helpers
    // ------------------------------------------------------------------------

    // Path nodes of entry e: root, then 1 + e[2], then 3 + e[2:1]
    function automatic plru_t tree_touch(input plru_t t, input upct_idx_t e);
        t[0]          = ~e[2];
        t[1 + e[2]]   = ~e[1];
        t[3 + e[2:1]] = ~e[0];
        return t;
    endfunction

    // Least recently used leaf, bits read from the root down
    function automatic upct_idx_t tree_victim(input plru_t t);
        upct_idx_t v;
        v[2] = t[0];
        v[1] = t[1 + v[2]];
        v[0] = t[3 + v[2:1]];
        return v;
    endfunction

    // Lowest entry holding this upper value, -1 if none
    function automatic int lookup(input upper_pc_t up);
        for (int i = 0; i < `UPCT_ENTRIES; i++) begin
            if (m_array[i] == up) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    task automatic drive(input logic uv, input full_pc_t pc, input logic rv, input read_req_t rq);
        @(posedge CLK);
        update_valid <= uv;
        update_pc    <= pc;
        read_valid   <= rv;
        read_req     <= rq;
    endtask

    // Next update response or target pulse, result left on the DUT outputs
    task automatic await_rsp(input logic on_target);
        int n;
        n = 0;
        do begin
            @(negedge CLK);
            n++;
        end while (!(on_target ? target_valid : update_rsp_valid) && n < RSP_WAIT);
        if (!(on_target ? target_valid : update_rsp_valid)) begin
            errors++;
            $display("no %s arrived within %0d cycles",
                     on_target ? "read target" : "update response", RSP_WAIT);
        end
    endtask

    task automatic send_update(input upper_pc_t up, input lower_pc_t lo);
        drive(1'b1, {up, lo}, 1'b0, '0);
        drive(1'b0, '0, 1'b0, '0);
        await_rsp(1'b0);
    endtask

    task automatic send_read(input upct_idx_t idx, input lower_pc_t lo);
        drive(1'b0, '0, 1'b1, {idx, lo});
        drive(1'b0, '0, 1'b0, '0);
        await_rsp(1'b1);
    endtask

    // ------------------------------------------------------------------------
    // Cycle model, compared and stepped between edges
    // ------------------------------------------------------------------------

    always @(negedge CLK) begin
        int        found;
        upct_idx_t pick;
        if (!nRST) begin
            for (int i = 0; i < `UPCT_ENTRIES; i++) begin
                m_array[i] = '0;
            end
            m_plru        = '0;
            m_u1_valid    = 1'b0;
            m_u1_upper    = '0;
            m_r1_valid    = 1'b0;
            m_r1_req      = '0;
            exp_rsp_valid = 1'b0;
            exp_tgt_valid = 1'b0;
        end else begin
            checks += 2;
            if (update_rsp_valid !== exp_rsp_valid
                || (exp_rsp_valid && update_rsp !== exp_rsp)) begin
                report_error($sformatf("update response %b/%h, model %b/%h",
                             update_rsp_valid, update_rsp, exp_rsp_valid, exp_rsp));
            end
            if (target_valid !== exp_tgt_valid || (exp_tgt_valid && target_pc !== exp_tgt)) begin
                report_error($sformatf("target %b/%h, model %b/%h",
                             target_valid, target_pc, exp_tgt_valid, exp_tgt));
            end
            // Update1 sees the table before the coming edge
            found = lookup(m_u1_upper);
            pick  = (found >= 0) ? upct_idx_t'(found) : tree_victim(m_plru);
            exp_rsp_valid = m_u1_valid;
            exp_rsp       = {pick, found >= 0};
            exp_tgt_valid = m_r1_valid;
            exp_tgt       = {m_array[m_r1_req.idx], m_r1_req.lower};
            // Read touch first so the update ends most recent
            if (m_r1_valid) begin
                m_plru = tree_touch(m_plru, m_r1_req.idx);
            end
            if (m_u1_valid) begin
                m_plru = tree_touch(m_plru, pick);
                if (found < 0) begin
                    m_array[pick] = m_u1_upper;
                end
            end
            m_u1_valid = update_valid;
            m_u1_upper = update_pc[`UPCT_PC_WIDTH-1:`UPCT_LOWER_WIDTH];
            m_r1_valid = read_valid;
            m_r1_req   = read_req;
        end
    end

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------

    task automatic test_reset_state();
        lower_pc_t lo;
        @(negedge CLK);
        if (update_rsp_valid !== 1'b0 || target_valid !== 1'b0) begin
            report_error("valid outputs not low after reset");
        end
        // Reads of 0..7 in order leave every tree bit at zero again
        for (int i = 0; i < `UPCT_ENTRIES; i++) begin
            lo = lower_pc_t'(37 * i + 5);
            send_read(upct_idx_t'(i), lo);
            if (target_pc !== {upper_pc_t'(0), lo}) begin
                report_error($sformatf("entry %0d reads %h after reset", i, target_pc));
            end
        end
    endtask

    task automatic test_allocation_order();
        upct_idx_t order [8] = '{0, 4, 2, 6, 1, 5, 3, 7};
        upper_pc_t up;
        for (int i = 0; i < 8; i++) begin
            up = upper_pc_t'(22'h2a0c1 + 22'h11d3 * i);
            send_update(up, lower_pc_t'(i));
            if (update_rsp.hit !== 1'b0 || update_rsp.idx !== order[i]) begin
                report_error($sformatf("allocation %0d got idx %0d hit %b, expected idx %0d",
                             i, update_rsp.idx, update_rsp.hit, order[i]));
            end
            stored[order[i]] = up;
        end
    endtask

    task automatic test_hits();
        upper_pc_t up;
        upct_idx_t first;
        send_update(stored[6], 10'h155);
        if (update_rsp.hit !== 1'b1 || update_rsp.idx !== 3'd6) begin
            report_error($sformatf("known upper gave idx %0d hit %b",
                         update_rsp.idx, update_rsp.hit));
        end
        send_read(3'd6, 10'h0f0);
        if (target_pc !== {stored[6], 10'h0f0}) begin
            report_error($sformatf("entry 6 reads %h after a hit", target_pc));
        end
        // Equal new uppers on back-to-back cycles, miss then hit
        up    = 22'h3c00f;
        // Miss lands on the current tree victim
        first = tree_victim(m_plru);
        drive(1'b1, {up, 10'h001}, 1'b0, '0);
        drive(1'b1, {up, 10'h002}, 1'b0, '0);
        drive(1'b0, '0, 1'b0, '0);
        @(negedge CLK);
        if (update_rsp_valid !== 1'b1 || update_rsp.hit !== 1'b0
            || update_rsp.idx !== first) begin
            report_error($sformatf("first of two equal updates gave idx %0d hit %b",
                         update_rsp.idx, update_rsp.hit));
        end
        @(negedge CLK);
        if (update_rsp_valid !== 1'b1 || update_rsp.hit !== 1'b1 || update_rsp.idx !== first) begin
            report_error($sformatf("second equal update gave idx %0d hit %b",
                         update_rsp.idx, update_rsp.hit));
        end
        stored[first] = up;
    endtask

    task automatic test_target_rebuild();
        full_pc_t  expect_q [$];
        lower_pc_t lo;
        int        got;
        got = 0;
        for (int i = 0; i < `UPCT_ENTRIES + 2; i++) begin
            if (i < `UPCT_ENTRIES) begin
                lo = lower_pc_t'($urandom);
                expect_q.push_back({stored[i], lo});
                drive(1'b0, '0, 1'b1, {upct_idx_t'(i), lo});
            end else begin
                drive(1'b0, '0, 1'b0, '0);
            end
            // Target shows two edges after its drive
            @(negedge CLK);
            if (target_valid === 1'b1) begin
                got++;
                if (expect_q.size() == 0 || target_pc !== expect_q[0]) begin
                    report_error($sformatf("back-to-back target %h out of order", target_pc));
                end else begin
                    void'(expect_q.pop_front());
                end
            end
        end
        if (got != `UPCT_ENTRIES) begin
            report_error($sformatf("%0d targets for %0d reads", got, `UPCT_ENTRIES));
        end
    endtask

    task automatic test_read_steering();
        upct_idx_t v;
        upct_idx_t w;
        plru_t     t;
        // Model is settled on this edge, no touch in flight
        drive(1'b0, '0, 1'b0, '0);
        v = tree_victim(m_plru);
        send_read(v, 10'h3ff);
        // Victim once the read touch has landed
        w = tree_victim(m_plru);
        send_update(22'h155aa, 10'h000);
        if (update_rsp.hit !== 1'b0 || update_rsp.idx !== w) begin
            report_error($sformatf("miss after reading entry %0d took %0d, expected %0d",
                         v, update_rsp.idx, w));
        end
        stored[w] = 22'h155aa;
        // Read in the other root half during a miss, order decides the root bit
        drive(1'b0, '0, 1'b0, '0);
        v = tree_victim(m_plru);
        t = tree_touch(tree_touch(m_plru, v ^ 3'd4), v);
        drive(1'b1, {22'h2bb44, 10'h000}, 1'b1, {v ^ 3'd4, 10'h123});
        drive(1'b0, '0, 1'b0, '0);
        await_rsp(1'b0);
        if (update_rsp.idx !== v || target_valid !== 1'b1
            || target_pc !== {stored[v ^ 3'd4], 10'h123}) begin
            report_error($sformatf("same-cycle miss idx %0d target %h",
                         update_rsp.idx, target_pc));
        end
        stored[v] = 22'h2bb44;
        send_update(22'h0e0e0, 10'h000);
        if (update_rsp.idx !== tree_victim(t)) begin
            report_error($sformatf("miss after read+update took %0d, expected %0d",
                         update_rsp.idx, tree_victim(t)));
        end
    endtask

    task automatic test_random_mix();
        upper_pc_t pool [6] = '{22'h0, 22'h155aa, 22'h3c00f, 22'h12345, 22'h2bb44, 22'h00777};
        for (int i = 0; i < 300; i++) begin
            drive(1'($urandom), {pool[$urandom % 6], lower_pc_t'($urandom)},
                  1'($urandom), {upct_idx_t'($urandom), lower_pc_t'($urandom)});
        end
        // Drain the last responses through the model compare
        repeat (3) drive(1'b0, '0, 1'b0, '0);
    endtask

    initial begin
        void'($urandom(48148));
        nRST         <= 1'b0;
        update_valid <= 1'b0;
        update_pc    <= '0;
        read_valid   <= 1'b0;
        read_req     <= '0;
        repeat (10) @(posedge CLK);
        nRST <= 1'b1;
        test_reset_state();
        test_allocation_order();
        test_hits();
        test_target_rebuild();
        test_read_steering();
        test_random_mix();
        $display("model checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        while (cycle_count < MAX_CYCLES) begin
            @(posedge CLK);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("model checks %0d, errors %0d", checks, errors);
        $display("TB FAILED");
        $finish;
    end

endmodule

/* hdl/upct_top.sv */
module upct_top
    import upct_pkg::*;
(
    input  logic        CLK,
    input  logic        nRST,

    // Update side
    input  logic        update_valid,
    input  full_pc_t    update_pc,

    // Read side
    input  logic        read_valid,
    input  read_req_t   read_req,

    // Index result of each update
    output logic        update_rsp_valid,
    output update_rsp_t update_rsp,

    // Rebuilt target of each read
    output logic        target_valid,
    output full_pc_t    target_pc
);

    // ------------------------------------------------------------------------
    // Internal wires
    // ------------------------------------------------------------------------

    logic        upd1_valid;
    update_req_t upd1_req;
    upct_array_t upct_array;
    logic        read_touch_valid;
    upct_idx_t   read_touch_idx;

    // Input register and PC split
    upct_update_in u_update_in (
        .CLK          (CLK),
        .nRST         (nRST),
        .update_valid (update_valid),
        .update_pc    (update_pc),
        .upd1_valid   (upd1_valid),
        .upd1_req     (upd1_req)
    );

    // Storage, match and replacement
    upct_table u_table (
        .CLK              (CLK),
        .nRST             (nRST),
        .upd1_valid       (upd1_valid),
        .upd1_req         (upd1_req),
        .read_touch_valid (read_touch_valid),
        .read_touch_idx   (read_touch_idx),
        .upct_array       (upct_array),
        .update_rsp_valid (update_rsp_valid),
        .update_rsp       (update_rsp)
    );

    // Read register and target rebuild
    upct_target_out u_target_out (
        .CLK              (CLK),
        .nRST             (nRST),
        .read_valid       (read_valid),
        .read_req         (read_req),
        .upct_array       (upct_array),
        .read_touch_valid (read_touch_valid),
        .read_touch_idx   (read_touch_idx),
        .target_valid     (target_valid),
        .target_pc        (target_pc)
    );

endmodule

/* hdl/upct_target_out.sv */
module upct_target_out
    import upct_pkg::*;
(
    input  logic        CLK,
    input  logic        nRST,

    // Read request from the target buffer
    input  logic        read_valid,
    input  read_req_t   read_req,

    // Current table contents
    input  upct_array_t upct_array,

    // Touch towards the PLRU
    output logic        read_touch_valid,
    output upct_idx_t   read_touch_idx,

    // Rebuilt target
    output logic        target_valid,
    output full_pc_t    target_pc
);

    // ------------------------------------------------------------------------
    // Request register
    // ------------------------------------------------------------------------

    logic      rd_valid_q;
    read_req_t rd_req_q;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rd_valid_q <= 1'b0;
            rd_req_q   <= '0;
        end else begin
            rd_valid_q <= read_valid;
            if (read_valid) begin
                rd_req_q <= read_req;
            end
        end
    end

    // Entry in use this cycle becomes most recent
    assign read_touch_valid = rd_valid_q;
    assign read_touch_idx   = rd_req_q.idx;

    // ------------------------------------------------------------------------
    // Target rebuild
    // ------------------------------------------------------------------------

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            target_valid <= 1'b0;
            target_pc    <= '0;
        end else begin
            target_valid <= rd_valid_q;
            // Shared upper bits joined with the request's own low bits
            if (rd_valid_q) begin
                target_pc <= {upct_array[rd_req_q.idx], rd_req_q.lower};
            end
        end
    end

endmodule

/* hdl/upct_table.sv */
`include "upct_cfg.svh"

module upct_table
    import upct_pkg::*;
(
    input  logic        CLK,
    input  logic        nRST,

    // Staged update
    input  logic        upd1_valid,
    input  update_req_t upd1_req,

    // Touch from the read side
    input  logic        read_touch_valid,
    input  upct_idx_t   read_touch_idx,

    // Table contents for target rebuild
    output upct_array_t upct_array,

    // Index result of the update
    output logic        update_rsp_valid,
    output update_rsp_t update_rsp
);

    // ------------------------------------------------------------------------
    // Replacement state
    // ------------------------------------------------------------------------

    logic      upd_touch_valid;
    upct_idx_t upd_touch_idx;
    upct_idx_t victim_idx;

    upct_plru u_plru (
        .CLK              (CLK),
        .nRST             (nRST),
        .read_touch_valid (read_touch_valid),
        .read_touch_idx   (read_touch_idx),
        .upd_touch_valid  (upd_touch_valid),
        .upd_touch_idx    (upd_touch_idx),
        .victim_idx       (victim_idx)
    );

    // ------------------------------------------------------------------------
    // Associative match
    // ------------------------------------------------------------------------

    logic      match_hit;
    upct_idx_t match_idx;
    upct_idx_t chosen_idx;

    always_comb begin
        match_hit = 1'b0;
        match_idx = '0;
        // Scan downwards so the lowest match is the one kept
        for (int i = `UPCT_ENTRIES - 1; i >= 0; i--) begin
            if (upct_array[i] == upd1_req.upper) begin
                match_hit = 1'b1;
                match_idx = upct_idx_t'(i);
            end
        end
    end

    // Hit keeps its entry, miss takes the victim
    assign chosen_idx = match_hit ? match_idx : victim_idx;

    // Every update refreshes its entry in the tree
    assign upd_touch_valid = upd1_valid;
    assign upd_touch_idx   = chosen_idx;

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            // All entries start as upper PC zero
            upct_array <= '0;
        end else begin
            if (upd1_valid && !match_hit) begin
                upct_array[chosen_idx] <= upd1_req.upper;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Response register
    // ------------------------------------------------------------------------

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            update_rsp_valid <= 1'b0;
            update_rsp       <= '0;
        end else begin
            update_rsp_valid <= upd1_valid;
            if (upd1_valid) begin
                update_rsp.idx <= chosen_idx;
                update_rsp.hit <= match_hit;
            end
        end
    end

endmodule

/* hdl/upct_plru.sv */
`include "upct_cfg.svh"

module upct_plru
    import upct_pkg::*;
(
    input  logic      CLK,
    input  logic      nRST,

    // Touch from the read side
    input  logic      read_touch_valid,
    input  upct_idx_t read_touch_idx,

    // Touch from the update side
    input  logic      upd_touch_valid,
    input  upct_idx_t upd_touch_idx,

    // Entry to replace on a miss
    output upct_idx_t victim_idx
);

    // ------------------------------------------------------------------------
    // Tree helpers
    // ------------------------------------------------------------------------

    // Heap order: node n has children 2n+1 and 2n+2
    // Bit value 0 points at the lower half as less recently used
    function automatic plru_t touch(input plru_t tree, input upct_idx_t idx);
        plru_t t;
        int    node;
        t    = tree;
        node = 0;
        for (int lvl = 0; lvl < `UPCT_LOG_ENTRIES; lvl++) begin
            // Point away from the touched half
            t[node] = ~idx[`UPCT_LOG_ENTRIES-1-lvl];
            node    = 2 * node + 1 + int'(idx[`UPCT_LOG_ENTRIES-1-lvl]);
        end
        return t;
    endfunction

    // Follow the pointers from the root down to a leaf
    function automatic upct_idx_t walk(input plru_t tree);
        upct_idx_t v;
        int        node;
        v    = '0;
        node = 0;
        for (int lvl = 0; lvl < `UPCT_LOG_ENTRIES; lvl++) begin
            v[`UPCT_LOG_ENTRIES-1-lvl] = tree[node];
            node = 2 * node + 1 + int'(tree[node]);
        end
        return v;
    endfunction

    // ------------------------------------------------------------------------
    // State
    // ------------------------------------------------------------------------

    plru_t plru_q;
    plru_t plru_rd;
    plru_t plru_d;

    always_comb begin
        // Read first, update second, so the update ends most recent
        plru_rd = read_touch_valid ? touch(plru_q, read_touch_idx) : plru_q;
        plru_d  = upd_touch_valid ? touch(plru_rd, upd_touch_idx) : plru_rd;
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            plru_q <= '0;
        end else begin
            plru_q <= plru_d;
        end
    end

    assign victim_idx = walk(plru_q);

endmodule

/* hdl/upct_update_in.sv */
`include "upct_cfg.svh"

module upct_update_in
    import upct_pkg::*;
(
    input  logic        CLK,
    input  logic        nRST,

    // Resolved branch target
    input  logic        update_valid,
    input  full_pc_t    update_pc,

    // Update1 stage towards the table
    output logic        upd1_valid,
    output update_req_t upd1_req
);

    // ------------------------------------------------------------------------
    // PC split
    // ------------------------------------------------------------------------

    update_req_t split_req;

    always_comb begin
        // Upper part goes to the table, lower part stays with the caller
        split_req.upper = update_pc[`UPCT_PC_WIDTH-1:`UPCT_LOWER_WIDTH];
        split_req.lower = update_pc[`UPCT_LOWER_WIDTH-1:0];
    end

    // ------------------------------------------------------------------------
    // Update1 register
    // ------------------------------------------------------------------------

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            upd1_valid <= 1'b0;
            upd1_req   <= '0;
        end else begin
            upd1_valid <= update_valid;
            // Hold the last request while idle
            if (update_valid) begin
                upd1_req <= split_req;
            end
        end
    end

endmodule

/* hdl/upct_pkg.sv */
`include "upct_cfg.svh"

package upct_pkg;

    // -----------------------------------------------------------------------
    // Vector types
    // -----------------------------------------------------------------------

    typedef logic [`UPCT_PC_WIDTH-1:0]     full_pc_t;
    typedef logic [`UPCT_UPPER_WIDTH-1:0]  upper_pc_t;
    typedef logic [`UPCT_LOWER_WIDTH-1:0]  lower_pc_t;
    typedef logic [`UPCT_LOG_ENTRIES-1:0]  upct_idx_t;

    // One tree bit per internal node
    typedef logic [`UPCT_ENTRIES-2:0]      plru_t;

    // Whole table contents, entry 0 in the low bits
    typedef upper_pc_t [`UPCT_ENTRIES-1:0] upct_array_t;

    // -----------------------------------------------------------------------
    // Request and response bundles
    // -----------------------------------------------------------------------

    // Staged update, PC already split
    typedef struct packed {
        upper_pc_t upper;
        lower_pc_t lower;
    } update_req_t;

    // Read of one entry plus the low PC bits to rejoin
    typedef struct packed {
        upct_idx_t idx;
        lower_pc_t lower;
    } read_req_t;

    // Index handed back to the target buffer
    typedef struct packed {
        upct_idx_t idx;
        logic      hit;
    } update_rsp_t;

endpackage

/* hdl/upct_cfg.svh */
`ifndef UPCT_CFG_SVH
`define UPCT_CFG_SVH

// ---------------------------------------------------------------------------
// Table geometry
// ---------------------------------------------------------------------------

// Entries in the upper-PC table
`define UPCT_ENTRIES 8
// Index width, log2 of the entry count
`define UPCT_LOG_ENTRIES 3

// ---------------------------------------------------------------------------
// PC split
// ---------------------------------------------------------------------------

// Full target PC
`define UPCT_PC_WIDTH 32
// Low bits kept in the target buffer itself
`define UPCT_LOWER_WIDTH 10
// Shared upper bits held per table entry
`define UPCT_UPPER_WIDTH 22

`endif
